/* source/rv_decode_pkg.sv */
// rv32im decode definitions
package rv_decode_pkg;

    typedef enum logic [6:0] {
        LOAD   = 7'b0000011,
        FENCE  = 7'b0001111,
        OP_IMM = 7'b0010011,
        AUIPC  = 7'b0010111,
        STORE  = 7'b0100011,
        OP     = 7'b0110011,
        LUI    = 7'b0110111,
        BRANCH = 7'b1100011,
        JALR   = 7'b1100111,
        JAL    = 7'b1101111,
        SYSTEM = 7'b1110011
    } opcode_e;

    // funct3 codes, grouped by instruction class
    typedef enum logic [2:0] {
        F3_ADDI, F3_SLLI, F3_SLTI, F3_SLTIU, F3_XORI, F3_SRI, F3_ORI, F3_ANDI
    } funct3_i_e;

    typedef enum logic [2:0] {
        F3_ADD_SUB, F3_SLL, F3_SLT, F3_SLTU, F3_XOR, F3_SR, F3_OR, F3_AND
    } funct3_r_e;

    typedef enum logic [2:0] {
        F3_MUL, F3_MULH, F3_MULHSU, F3_MULHU, F3_DIV, F3_DIVU, F3_REM, F3_REMU
    } funct3_m_e;

    typedef enum logic [2:0] {
        F3_LB = 3'b000, F3_LH = 3'b001, F3_LW = 3'b010, F3_LBU = 3'b100, F3_LHU = 3'b101
    } funct3_load_e;

    typedef enum logic [2:0] {
        F3_SB = 3'b000, F3_SH = 3'b001, F3_SW = 3'b010
    } funct3_store_e;

    typedef enum logic [2:0] {
        F3_BEQ = 3'b000, F3_BNE = 3'b001, F3_BLT = 3'b100,
        F3_BGE = 3'b101, F3_BLTU = 3'b110, F3_BGEU = 3'b111
    } funct3_branch_e;

    typedef enum logic [2:0] {
        F3_CSRRW = 3'b001, F3_CSRRS = 3'b010, F3_CSRRC = 3'b011,
        F3_CSRRWI = 3'b101, F3_CSRRSI = 3'b110, F3_CSRRCI = 3'b111
    } funct3_csr_e;

    localparam logic [6:0] FUNCT7_BASE   = 7'b0000000;
    localparam logic [6:0] FUNCT7_ALT    = 7'b0100000;  // sub, sra
    localparam logic [6:0] FUNCT7_MULDIV = 7'b0000001;

    localparam logic [31:0] INST_NOP = 32'h0000_0013;  // addi x0, x0, 0

    typedef enum logic [2:0] {
        HOLD_NONE  = 3'd0,
        HOLD_PC    = 3'd1,
        HOLD_IF    = 3'd2,
        PIPE_CLEAR = 3'd3
    } hold_e;

    // machine csr addresses
    localparam logic [11:0] CSR_MSTATUS  = 12'h300;
    localparam logic [11:0] CSR_MTVEC    = 12'h305;
    localparam logic [11:0] CSR_MSCRATCH = 12'h340;
    localparam logic [11:0] CSR_MEPC     = 12'h341;
    localparam logic [11:0] CSR_MCAUSE   = 12'h342;

    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        opcode_e    opcode;
    } r_fmt_t;

    typedef struct packed {
        logic [11:0] imm;  // csr address for system ops
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [4:0]  rd;
        opcode_e     opcode;
    } i_fmt_t;

    typedef union packed {
        r_fmt_t r_fmt;
        i_fmt_t i_fmt;
    } inst_u;

    typedef struct packed {
        inst_u       inst;
        logic [31:0] pc;
        logic        next_type;
    } fetch_t;

    // bundle handed to execute
    typedef struct packed {
        logic [31:0] inst;
        logic [31:0] pc;
        logic        next_type;
        logic [31:0] rs1_data;
        logic [31:0] rs2_data;
        logic [4:0]  rs1_addr;
        logic [4:0]  rs2_addr;
        logic [4:0]  rd;
        logic [31:0] csr_data;
        logic [11:0] csr_waddr;
    } id_ex_t;

endpackage

/* source/if_id_reg.sv */
// fetch to decode register
module if_id_reg (
    input  logic                  clk_i,
    input  logic                  rst_n_i,
    input  rv_decode_pkg::fetch_t fetch_i,
    input  logic                  fetch_valid_i,
    input  logic                  ex_ready_i,
    input  rv_decode_pkg::hold_e  hold_flag_i,
    output rv_decode_pkg::fetch_t fetch_o,
    output logic                  fetch_valid_o,
    output logic                  fetch_ready_o
);
    import rv_decode_pkg::*;

    logic load;
    logic clear;

    assign fetch_ready_o = ex_ready_i;  // no skid, ready passes straight back
    assign load          = fetch_valid_i & fetch_ready_o;
    assign clear         = (hold_flag_i == PIPE_CLEAR) | (fetch_ready_o & ~fetch_valid_i);

    // clear wins over load
    always_ff @(posedge clk_i) begin
        if (!rst_n_i || clear) begin
            fetch_o.inst      <= INST_NOP;
            fetch_o.pc        <= '0;
            fetch_o.next_type <= 1'b0;
            fetch_valid_o     <= 1'b0;
        end else if (load) begin
            fetch_o       <= fetch_i;
            fetch_valid_o <= 1'b1;
        end
    end

    // valid only appears one cycle after a valid fetch
    valid_origin_chk: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        $rose(fetch_valid_o) |-> $past(fetch_valid_i))
        else $error("fetch_valid_o rose without a valid fetch");

endmodule

/* source/id_stage.sv */
// instruction decode stage
module id_stage #(
    parameter int unsigned NumGpr = 32
) (
    input  logic                  clk_i,
    input  logic                  rst_n_i,
    input  rv_decode_pkg::fetch_t fetch_i,
    input  logic                  fetch_valid_i,
    input  logic                  ex_ready_i,
    input  rv_decode_pkg::hold_e  hold_flag_i,
    output logic [4:0]            rs1_addr_o,
    output logic [4:0]            rs2_addr_o,
    output logic                  rs1_en_o,
    output logic                  rs2_en_o,
    input  logic [31:0]           rs1_data_i,
    input  logic [31:0]           rs2_data_i,
    output logic [11:0]           csr_raddr_o,
    input  logic [31:0]           csr_rdata_i,
    output rv_decode_pkg::id_ex_t id_ex_o
);
    import rv_decode_pkg::*;

    localparam int unsigned IdxW = $clog2(NumGpr);

    inst_u       inst;
    logic [2:0]  funct3;
    logic [6:0]  funct7;
    logic [11:0] csr_waddr;
    logic        load;
    logic        clear;
    id_ex_t      id_ex_d;

    assign inst   = fetch_i.inst;
    assign funct3 = inst.r_fmt.funct3;
    assign funct7 = inst.r_fmt.funct7;

    // addresses go out unconditionally, the enables gate the reads
    assign rs1_addr_o = inst.r_fmt.rs1;
    assign rs2_addr_o = inst.r_fmt.rs2;

    assign load  = ex_ready_i & fetch_valid_i;
    assign clear = (hold_flag_i == PIPE_CLEAR) | (ex_ready_i & ~fetch_valid_i);

    always_comb begin
        rs1_en_o    = 1'b0;
        rs2_en_o    = 1'b0;
        csr_raddr_o = '0;
        csr_waddr   = '0;

        case (inst.r_fmt.opcode)
            OP_IMM: begin
                case (funct3)
                    F3_ADDI, F3_SLLI, F3_SLTI, F3_SLTIU,
                    F3_XORI, F3_SRI, F3_ORI, F3_ANDI: rs1_en_o = 1'b1;
                    default: ;
                endcase
            end
            OP: begin
                if (funct7 == FUNCT7_BASE || funct7 == FUNCT7_ALT) begin
                    case (funct3)
                        F3_ADD_SUB, F3_SLL, F3_SLT, F3_SLTU,
                        F3_XOR, F3_SR, F3_OR, F3_AND: begin
                            rs1_en_o = 1'b1;
                            rs2_en_o = 1'b1;
                        end
                        default: ;
                    endcase
                end else if (funct7 == FUNCT7_MULDIV) begin
                    case (funct3)
                        F3_MUL, F3_MULH, F3_MULHSU, F3_MULHU,
                        F3_DIV, F3_DIVU, F3_REM, F3_REMU: begin
                            rs1_en_o = 1'b1;
                            rs2_en_o = 1'b1;
                        end
                        default: ;
                    endcase
                end
            end
            LOAD: begin
                case (funct3)
                    F3_LB, F3_LH, F3_LW, F3_LBU, F3_LHU: rs1_en_o = 1'b1;
                    default: ;
                endcase
            end
            STORE: begin
                case (funct3)
                    F3_SB, F3_SH, F3_SW: begin
                        rs1_en_o = 1'b1;  // base
                        rs2_en_o = 1'b1;  // store data
                    end
                    default: ;
                endcase
            end
            BRANCH: begin
                case (funct3)
                    F3_BEQ, F3_BNE, F3_BLT, F3_BGE, F3_BLTU, F3_BGEU: begin
                        rs1_en_o = 1'b1;
                        rs2_en_o = 1'b1;
                    end
                    default: ;
                endcase
            end
            JALR: rs1_en_o = 1'b1;
            SYSTEM: begin
                csr_raddr_o = inst.i_fmt.imm;
                csr_waddr   = inst.i_fmt.imm;
                case (funct3)
                    F3_CSRRW, F3_CSRRS, F3_CSRRC: rs1_en_o = 1'b1;
                    // immediate forms carry uimm in the rs1 field
                    F3_CSRRWI, F3_CSRRSI, F3_CSRRCI: ;
                    default: ;
                endcase
            end
            JAL, LUI, AUIPC, FENCE: ;  // no register source
            default: ;
        endcase
    end

    always_comb begin
        id_ex_d.inst      = inst;
        id_ex_d.pc        = fetch_i.pc;
        id_ex_d.next_type = fetch_i.next_type;
        id_ex_d.rs1_data  = rs1_data_i;
        id_ex_d.rs2_data  = rs2_data_i;
        id_ex_d.rs1_addr  = rs1_addr_o;
        id_ex_d.rs2_addr  = rs2_addr_o;
        id_ex_d.rd        = inst.r_fmt.rd;
        id_ex_d.csr_data  = csr_rdata_i;
        id_ex_d.csr_waddr = csr_waddr;
    end

    // a cleared bundle is a nop with every other field zero
    always_ff @(posedge clk_i) begin
        if (!rst_n_i || clear) begin
            id_ex_o      <= '0;
            id_ex_o.inst <= INST_NOP;
        end else if (load) begin
            id_ex_o <= id_ex_d;
        end
    end

    // enabled reads must land inside the implemented register set
    gpr_index_chk: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        fetch_valid_i |-> (!rs1_en_o || (rs1_addr_o >> IdxW) == '0)
                       && (!rs2_en_o || (rs2_addr_o >> IdxW) == '0))
        else $error("register index beyond NumGpr-1");

endmodule

/* source/gpr_file.sv */
// general purpose register file
module gpr_file #(
    parameter int unsigned NumGpr = 32
) (
    input  logic        clk_i,
    input  logic        rst_n_i,
    input  logic        we_i,
    input  logic [4:0]  waddr_i,
    input  logic [31:0] wdata_i,
    input  logic [4:0]  raddr1_i,
    input  logic [4:0]  raddr2_i,
    input  logic        ren1_i,
    input  logic        ren2_i,
    output logic [31:0] rdata1_o,
    output logic [31:0] rdata2_o
);
    localparam int unsigned IdxW = $clog2(NumGpr);

    logic [31:0] regs [NumGpr];

    // upper indexes have no storage under rv32e
    function automatic logic in_range(input logic [4:0] addr);
        return (addr >> IdxW) == 5'd0;
    endfunction

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            for (int i = 0; i < NumGpr; i++) begin
                regs[i] <= '0;
            end
        end else if (we_i && waddr_i != 5'd0 && in_range(waddr_i)) begin
            regs[waddr_i[IdxW-1:0]] <= wdata_i;  // x0 never written
        end
    end

    // no bypass, a same-cycle write is seen next cycle
    assign rdata1_o = (ren1_i && in_range(raddr1_i)) ? regs[raddr1_i[IdxW-1:0]] : '0;
    assign rdata2_o = (ren2_i && in_range(raddr2_i)) ? regs[raddr2_i[IdxW-1:0]] : '0;

    // x0 keeps reading zero after a write aimed at it
    x0_zero_chk: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        (we_i && waddr_i == 5'd0) |=>
            (raddr1_i != 5'd0 || rdata1_o == '0) && (raddr2_i != 5'd0 || rdata2_o == '0))
        else $error("x0 read nonzero after write");

endmodule

/* source/csr_file.sv */
// machine csr file
module csr_file (
    input  logic        clk_i,
    input  logic        rst_n_i,
    input  logic [11:0] raddr_i,
    output logic [31:0] rdata_o,
    input  logic        we_i,
    input  logic [11:0] waddr_i,
    input  logic [31:0] wdata_i
);
    import rv_decode_pkg::*;

    logic [31:0] mstatus;
    logic [31:0] mtvec;
    logic [31:0] mscratch;
    logic [31:0] mepc;
    logic [31:0] mcause;

    // write port stands in for write-back
    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            mstatus  <= '0;
            mtvec    <= '0;  // trap base at zero
            mscratch <= '0;
            mepc     <= '0;
            mcause   <= '0;
        end else if (we_i) begin
            case (waddr_i)
                CSR_MSTATUS:  mstatus  <= wdata_i;
                CSR_MTVEC:    mtvec    <= wdata_i;
                CSR_MSCRATCH: mscratch <= wdata_i;
                CSR_MEPC:     mepc     <= wdata_i;
                CSR_MCAUSE:   mcause   <= wdata_i;
                default: ;  // unimplemented, write dropped
            endcase
        end
    end

    // combinational read, old value during a write
    always_comb begin
        case (raddr_i)
            CSR_MSTATUS:  rdata_o = mstatus;
            CSR_MTVEC:    rdata_o = mtvec;
            CSR_MSCRATCH: rdata_o = mscratch;
            CSR_MEPC:     rdata_o = mepc;
            CSR_MCAUSE:   rdata_o = mcause;
            default:      rdata_o = '0;
        endcase
    end

endmodule

/* source/decode_top.sv */
// rv32im decode stage top
module decode_top #(
    parameter int unsigned NumGpr = 32
) (
    input  logic                  clk_i,
    input  logic                  rst_n_i,
    input  rv_decode_pkg::fetch_t fetch_i,
    input  logic                  fetch_valid_i,
    input  logic                  ex_ready_i,
    input  rv_decode_pkg::hold_e  hold_flag_i,
    input  logic                  gpr_we_i,
    input  logic [4:0]            gpr_waddr_i,
    input  logic [31:0]           gpr_wdata_i,
    input  logic                  csr_we_i,
    input  logic [11:0]           csr_waddr_i,
    input  logic [31:0]           csr_wdata_i,
    output logic                  fetch_ready_o,
    output rv_decode_pkg::id_ex_t id_ex_o
);
    import rv_decode_pkg::*;

    fetch_t      fetch_q;
    logic        fetch_valid_q;
    logic [4:0]  rs1_addr;
    logic [4:0]  rs2_addr;
    logic        rs1_en;
    logic        rs2_en;
    logic [31:0] rs1_data;
    logic [31:0] rs2_data;
    logic [11:0] csr_raddr;
    logic [31:0] csr_rdata;

    if_id_reg u_if_id (
        .clk_i        (clk_i),
        .rst_n_i      (rst_n_i),
        .fetch_i      (fetch_i),
        .fetch_valid_i(fetch_valid_i),
        .ex_ready_i   (ex_ready_i),
        .hold_flag_i  (hold_flag_i),
        .fetch_o      (fetch_q),
        .fetch_valid_o(fetch_valid_q),
        .fetch_ready_o(fetch_ready_o)
    );

    id_stage #(
        .NumGpr(NumGpr)
    ) u_id (
        .clk_i        (clk_i),
        .rst_n_i      (rst_n_i),
        .fetch_i      (fetch_q),
        .fetch_valid_i(fetch_valid_q),
        .ex_ready_i   (ex_ready_i),
        .hold_flag_i  (hold_flag_i),
        .rs1_addr_o   (rs1_addr),
        .rs2_addr_o   (rs2_addr),
        .rs1_en_o     (rs1_en),
        .rs2_en_o     (rs2_en),
        .rs1_data_i   (rs1_data),
        .rs2_data_i   (rs2_data),
        .csr_raddr_o  (csr_raddr),
        .csr_rdata_i  (csr_rdata),
        .id_ex_o      (id_ex_o)
    );

    // operand reads return in the decode cycle
    gpr_file #(
        .NumGpr(NumGpr)
    ) u_gpr (
        .clk_i   (clk_i),
        .rst_n_i (rst_n_i),
        .we_i    (gpr_we_i),
        .waddr_i (gpr_waddr_i),
        .wdata_i (gpr_wdata_i),
        .raddr1_i(rs1_addr),
        .raddr2_i(rs2_addr),
        .ren1_i  (rs1_en),
        .ren2_i  (rs2_en),
        .rdata1_o(rs1_data),
        .rdata2_o(rs2_data)
    );

    csr_file u_csr (
        .clk_i  (clk_i),
        .rst_n_i(rst_n_i),
        .raddr_i(csr_raddr),
        .rdata_o(csr_rdata),
        .we_i   (csr_we_i),
        .waddr_i(csr_waddr_i),
        .wdata_i(csr_wdata_i)
    );

endmodule

/* tests/tb_decode_top.sv */
// decode stage testbench
module tb_decode_top;
    timeunit 1ns;
    timeprecision 100ps;
    import rv_decode_pkg::*;

    logic        clk;
    logic        rst_n;
    fetch_t      fetch;
    logic        fetch_valid;
    logic        ex_ready;
    hold_e       hold_flag;
    logic        gpr_we;
    logic [4:0]  gpr_waddr;
    logic [31:0] gpr_wdata;
    logic        csr_we;
    logic [11:0] csr_waddr;
    logic [31:0] csr_wdata;
    logic        fetch_ready;
    id_ex_t      id_ex;

    // reference model of the registers and both pipeline stages
    logic [31:0] gpr_m [32];
    logic [31:0] csr_m [5];
    fetch_t      s1_fetch;
    logic        s1_valid;
    id_ex_t      exp_q;
    logic        last_accept;
    logic [31:0] pc_cnt;
    int          n_checks;
    int          n_errors;

    decode_top #(
        .NumGpr(32)
    ) dut_i (
        .clk_i        (clk),
        .rst_n_i      (rst_n),
        .fetch_i      (fetch),
        .fetch_valid_i(fetch_valid),
        .ex_ready_i   (ex_ready),
        .hold_flag_i  (hold_flag),
        .gpr_we_i     (gpr_we),
        .gpr_waddr_i  (gpr_waddr),
        .gpr_wdata_i  (gpr_wdata),
        .csr_we_i     (csr_we),
        .csr_waddr_i  (csr_waddr),
        .csr_wdata_i  (csr_wdata),
        .fetch_ready_o(fetch_ready),
        .id_ex_o      (id_ex)
    );

    always #20 clk = ~clk;

    task automatic cmp_id_ex(input id_ex_t got, input id_ex_t exp, input string msg);
        n_checks++;
        if (got !== exp) begin
            n_errors++;
            $display("mismatch at %0t: %s got %h expected %h", $time, msg, got, exp);
        end
    endtask

    task automatic cmp_bit(input logic got, input logic exp, input string msg);
        n_checks++;
        if (got !== exp) begin
            n_errors++;
            $display("mismatch at %0t: %s got %b expected %b", $time, msg, got, exp);
        end
    endtask

    task automatic abort_run(input string why);
        $display("timeout: %s", why);
        $display("Checks failed");
        $finish;
    endtask

    task automatic report_test(input string name, input int e0);
        $display("test %-14s finished with %0d errors", name, n_errors - e0);
    endtask

    function automatic id_ex_t nop_bundle();
        id_ex_t b;
        b = '0;
        b.inst = INST_NOP;
        return b;
    endfunction

    function automatic int csr_slot(input logic [11:0] a);
        case (a)
            CSR_MSTATUS:  return 0;
            CSR_MTVEC:    return 1;
            CSR_MSCRATCH: return 2;
            CSR_MEPC:     return 3;
            CSR_MCAUSE:   return 4;
            default:      return -1;
        endcase
    endfunction

    function automatic logic [31:0] csr_read(input logic [11:0] a);
        int slot;
        slot = csr_slot(a);
        return (slot < 0) ? 32'h0 : csr_m[slot];
    endfunction

    // expected bundle from the enable rules and the register model
    function automatic id_ex_t ref_decode(input fetch_t f);
        id_ex_t      b;
        logic [31:0] w;
        logic [6:0]  f7;
        logic [2:0]  f3;
        logic        en1;
        logic        en2;
        w   = f.inst;
        f7  = w[31:25];
        f3  = w[14:12];
        en1 = 1'b0;
        en2 = 1'b0;
        case (w[6:0])
            OP_IMM: en1 = 1'b1;
            OP: begin
                en1 = (f7 == 7'h00) || (f7 == 7'h20) || (f7 == 7'h01);
                en2 = en1;
            end
            LOAD:   en1 = (f3 != 3'd3) && (f3 < 3'd6);
            STORE: begin
                en1 = (f3 < 3'd3);
                en2 = en1;
            end
            BRANCH: begin
                en1 = (f3 != 3'd2) && (f3 != 3'd3);
                en2 = en1;
            end
            JALR:   en1 = 1'b1;
            SYSTEM: en1 = (f3 == 3'd1) || (f3 == 3'd2) || (f3 == 3'd3);  // register forms
            default: ;
        endcase
        b           = '0;
        b.inst      = w;
        b.pc        = f.pc;
        b.next_type = f.next_type;
        b.rs1_addr  = w[19:15];
        b.rs2_addr  = w[24:20];
        b.rd        = w[11:7];
        b.rs1_data  = en1 ? gpr_m[w[19:15]] : 32'h0;
        b.rs2_data  = en2 ? gpr_m[w[24:20]] : 32'h0;
        if (w[6:0] == SYSTEM) begin
            b.csr_waddr = w[31:20];
            b.csr_data  = csr_read(w[31:20]);
        end
        return b;
    endfunction

    function automatic logic [31:0] enc(input logic [6:0] f7, input logic [4:0] rs2,
                                        input logic [4:0] rs1, input logic [2:0] f3,
                                        input logic [4:0] rd, input logic [6:0] op);
        return {f7, rs2, rs1, f3, rd, op};
    endfunction

    function automatic logic [31:0] enc_i(input logic [11:0] imm, input logic [4:0] rs1,
                                          input logic [2:0] f3, input logic [4:0] rd,
                                          input logic [6:0] op);
        return {imm, rs1, f3, rd, op};
    endfunction

    function automatic logic [11:0] pick_csr();
        case ($urandom_range(0, 5))
            0:       return CSR_MSTATUS;
            1:       return CSR_MTVEC;
            2:       return CSR_MSCRATCH;
            3:       return CSR_MEPC;
            4:       return CSR_MCAUSE;
            default: return 12'h7c0;  // not implemented
        endcase
    endfunction

    function automatic logic [31:0] rand_inst();
        logic [4:0]  rs1;
        logic [4:0]  rs2;
        logic [4:0]  rd;
        logic [2:0]  f3;
        logic [11:0] imm;
        rs1 = $urandom;
        rs2 = $urandom;
        rd  = $urandom;
        f3  = $urandom;
        imm = $urandom;
        case ($urandom_range(0, 9))
            0: return enc_i(imm, rs1, f3, rd, OP_IMM);
            1: begin
                if ($urandom_range(0, 1) == 1) begin
                    return enc(FUNCT7_ALT, rs2, rs1, f3[0] ? 3'd5 : 3'd0, rd, OP);
                end
                return enc(FUNCT7_BASE, rs2, rs1, f3, rd, OP);
            end
            2: return enc(FUNCT7_MULDIV, rs2, rs1, f3, rd, OP);
            3: begin
                f3 = $urandom_range(0, 4);
                if (f3 > 3'd2) f3 = f3 + 3'd1;  // skip 3
                return enc_i(imm, rs1, f3, rd, LOAD);
            end
            4: return enc(imm[11:5], rs2, rs1, 3'($urandom_range(0, 2)), imm[4:0], STORE);
            5: begin
                f3 = $urandom_range(0, 5);
                if (f3 > 3'd1) f3 = f3 + 3'd2;
                return enc(imm[11:5], rs2, rs1, f3, imm[4:0], BRANCH);
            end
            6: return enc_i(imm, rs1, 3'd0, rd, JALR);
            7: return enc_i(imm, rs1, f3, rd, LUI);
            8: return enc_i(imm, rs1, f3, rd, AUIPC);
            default: begin
                f3 = $urandom_range(1, 6);
                if (f3 > 3'd3) f3 = f3 + 3'd1;
                return enc_i(pick_csr(), rs1, f3, rd, SYSTEM);
            end
        endcase
    endfunction

    // advance one clock with the reference model stepped alongside
    task automatic tick();
        id_ex_t nxt;
        logic   pipe_clr;
        logic   ld1;
        logic   cl1;
        logic   ld2;
        logic   cl2;
        int     slot;
        pipe_clr = (hold_flag == PIPE_CLEAR);
        cl1      = pipe_clr || (ex_ready && !fetch_valid);
        ld1      = fetch_valid && ex_ready;
        cl2      = pipe_clr || (ex_ready && !s1_valid);
        ld2      = ex_ready && s1_valid;
        if (cl2) begin
            nxt = nop_bundle();
        end else if (ld2) begin
            nxt = ref_decode(s1_fetch);  // reads old register values
        end else begin
            nxt = exp_q;
        end
        @(posedge clk);
        cmp_bit(fetch_ready, ex_ready, "fetch_ready_o against ex_ready_i");
        last_accept = fetch_ready && fetch_valid;
        if (cl1) begin
            s1_fetch      = '0;
            s1_fetch.inst = INST_NOP;
            s1_valid      = 1'b0;
        end else if (ld1) begin
            s1_fetch = fetch;
            s1_valid = 1'b1;
        end
        exp_q = nxt;
        if (gpr_we && gpr_waddr != 5'd0) gpr_m[gpr_waddr] = gpr_wdata;
        slot = csr_slot(csr_waddr);
        if (csr_we && slot >= 0) csr_m[slot] = csr_wdata;
        #2;
        cmp_id_ex(id_ex, exp_q, "id_ex_o bundle");
    endtask

    task automatic bubble();
        fetch_valid = 1'b0;
        tick();
    endtask

    task automatic issue(input logic [31:0] word);
        int waited;
        waited           = 0;
        fetch.inst       = word;
        fetch.pc         = pc_cnt;
        fetch.next_type  = pc_cnt[2];
        fetch_valid      = 1'b1;
        tick();
        while (!last_accept) begin
            waited++;
            if (waited > 20) abort_run("fetch word was never accepted");
            tick();
        end
        pc_cnt      = pc_cnt + 32'd4;
        fetch_valid = 1'b0;
    endtask

    task automatic drain();
        int waited;
        waited = 0;
        bubble();
        while (s1_valid) begin
            waited++;
            if (waited > 10) abort_run("decode pipeline did not drain");
            bubble();
        end
        bubble();  // last bundle followed by a bubble
    endtask

    task automatic write_gpr(input logic [4:0] a, input logic [31:0] d);
        gpr_we    = 1'b1;
        gpr_waddr = a;
        gpr_wdata = d;
        bubble();
        gpr_we = 1'b0;
    endtask

    task automatic write_csr(input logic [11:0] a, input logic [31:0] d);
        csr_we    = 1'b1;
        csr_waddr = a;
        csr_wdata = d;
        bubble();
        csr_we = 1'b0;
    endtask

    task automatic test_reset();
        int e0;
        e0 = n_errors;
        cmp_id_ex(id_ex, nop_bundle(), "bundle after reset");
        cmp_bit(fetch_ready, 1'b1, "fetch_ready_o after reset");
        ex_ready = 1'b0;
        bubble();
        bubble();
        ex_ready = 1'b1;
        bubble();
        report_test("reset", e0);
    endtask

    task automatic test_gpr_operands();
        int e0;
        e0 = n_errors;
        for (int i = 1; i < 10; i++) begin
            write_gpr(5'(i), $urandom);
        end
        write_gpr(5'd0, 32'hdead_beef);  // must not stick
        issue(enc(FUNCT7_BASE, 5'd2, 5'd1, F3_ADD_SUB, 5'd3, OP));
        issue(enc(FUNCT7_ALT, 5'd0, 5'd4, F3_ADD_SUB, 5'd5, OP));
        issue(enc(FUNCT7_MULDIV, 5'd8, 5'd0, F3_MUL, 5'd6, OP));
        issue(enc_i(12'h123, 5'd6, F3_ADDI, 5'd7, OP_IMM));
        issue(enc(7'h01, 5'd7, 5'd5, F3_SW, 5'd4, STORE));
        issue(enc_i(12'habc, 5'd3, 3'd2, 5'd9, LUI));
        drain();
        report_test("gpr_operands", e0);
    endtask

    task automatic test_csr_access();
        int e0;
        e0 = n_errors;
        write_csr(CSR_MSTATUS, $urandom);
        write_csr(CSR_MTVEC, $urandom);
        write_csr(CSR_MSCRATCH, $urandom);
        write_csr(CSR_MEPC, $urandom);
        write_csr(CSR_MCAUSE, $urandom);
        write_csr(12'h7c0, $urandom);  // dropped
        write_gpr(5'd10, $urandom);
        issue(enc_i(CSR_MSCRATCH, 5'd10, F3_CSRRW, 5'd11, SYSTEM));
        issue(enc_i(CSR_MEPC, 5'd10, F3_CSRRSI, 5'd12, SYSTEM));
        issue(enc_i(CSR_MCAUSE, 5'd10, F3_CSRRW, 5'd13, SYSTEM));
        issue(enc_i(12'h7c0, 5'd10, F3_CSRRW, 5'd14, SYSTEM));
        drain();
        report_test("csr_access", e0);
    endtask

    task automatic test_back_pressure();
        id_ex_t snap;
        int     e0;
        e0 = n_errors;
        for (int i = 0; i < 3; i++) begin
            issue(rand_inst());
        end
        ex_ready        = 1'b0;
        fetch.inst      = rand_inst();
        fetch.pc        = pc_cnt;
        fetch.next_type = pc_cnt[2];
        fetch_valid     = 1'b1;
        snap            = exp_q;
        for (int i = 0; i < 4; i++) begin
            tick();
            cmp_id_ex(id_ex, snap, "bundle held under back-pressure");
            cmp_bit(fetch_ready, 1'b0, "fetch_ready_o under back-pressure");
        end
        ex_ready = 1'b1;
        issue(fetch.inst);  // the held word again at the same pc
        issue(rand_inst());
        drain();
        report_test("back_pressure", e0);
    endtask

    task automatic test_pipe_clear();
        int e0;
        e0 = n_errors;
        issue(rand_inst());
        issue(rand_inst());
        fetch.inst  = rand_inst();
        fetch_valid = 1'b1;
        hold_flag   = PIPE_CLEAR;
        tick();
        hold_flag = HOLD_NONE;
        cmp_id_ex(id_ex, nop_bundle(), "bundle after pipe clear");
        issue(rand_inst());
        issue(rand_inst());
        drain();
        report_test("pipe_clear", e0);
    endtask

    task automatic test_random_stream();
        int e0;
        e0 = n_errors;
        for (int n = 0; n < 200; n++) begin
            if ($urandom_range(0, 3) == 0) begin
                repeat ($urandom_range(1, 2)) bubble();
            end
            gpr_we    = ($urandom_range(0, 7) == 0);  // write-back alongside decode
            gpr_waddr = $urandom;
            gpr_wdata = $urandom;
            issue(rand_inst());
            gpr_we = 1'b0;
        end
        drain();
        report_test("random_stream", e0);
    endtask

    initial begin
        void'($urandom(32'habeb_f4a5));
        clk         = 1'b0;
        rst_n       = 1'b0;
        fetch       = '0;
        fetch.inst  = INST_NOP;
        fetch_valid = 1'b0;
        ex_ready    = 1'b1;
        hold_flag   = HOLD_NONE;
        gpr_we      = 1'b0;
        gpr_waddr   = '0;
        gpr_wdata   = '0;
        csr_we      = 1'b0;
        csr_waddr   = '0;
        csr_wdata   = '0;
        for (int i = 0; i < 32; i++) begin
            gpr_m[i] = '0;
        end
        for (int i = 0; i < 5; i++) begin
            csr_m[i] = '0;
        end
        s1_fetch      = '0;
        s1_fetch.inst = INST_NOP;
        s1_valid      = 1'b0;
        exp_q         = nop_bundle();
        last_accept   = 1'b0;
        pc_cnt        = 32'h0000_1000;
        n_checks      = 0;
        n_errors      = 0;

        repeat (16) @(posedge clk);
        #2;
        rst_n = 1'b1;

        test_reset();
        test_gpr_operands();
        test_csr_access();
        test_back_pressure();
        test_pipe_clear();
        test_random_stream();

        $display("%0d checks, %0d errors", n_checks, n_errors);
        if (n_errors == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule

/* rv_decode_stage.f */
source/rv_decode_pkg.sv
source/if_id_reg.sv
source/id_stage.sv
source/gpr_file.sv
source/csr_file.sv
source/decode_top.sv
tests/tb_decode_top.sv
